// File: hdl/i2c_wr_consts.svh
`ifndef I2C_WR_CONSTS_SVH
`define I2C_WR_CONSTS_SVH

// number of bus engines; I2C_CH_W must hold a channel number
`define I2C_CHANNELS 4
`define I2C_CH_W 2

// clk cycles per quarter of an SCL period
`define I2C_QUARTER 4

// field widths of a command
`define I2C_ADDR_W 7
`define I2C_BYTE_W 8

`endif

// File: hdl/i2c_wr_pkg.sv
`default_nettype none

`include "i2c_wr_consts.svh"

package i2c_wr_pkg;

	typedef struct packed {
		logic [`I2C_CH_W-1:0]   channel;
		logic [`I2C_ADDR_W-1:0] addr;     // 7-bit target address
		logic [`I2C_BYTE_W-1:0] reg_idx;
		logic [`I2C_BYTE_W-1:0] data;
		logic [`I2C_BYTE_W-1:0] tag;      // returned unchanged with the result
	} i2c_cmd_t;

	// where a transaction ended
	typedef enum logic [1:0] {
		PH_OK,
		PH_ADDR_NACK,
		PH_REG_NACK,
		PH_DATA_NACK
	} i2c_phase_e;

	typedef struct packed {
		logic [`I2C_CH_W-1:0]   channel;
		logic [`I2C_BYTE_W-1:0] tag;
		i2c_phase_e             phase;
		logic [`I2C_ADDR_W-1:0] addr;
	} i2c_res_t;

	typedef enum logic [2:0] {
		IDLE,
		START,
		SHIFT,
		ACK,
		STOP
	} i2c_eng_state_e;

endpackage

`default_nettype wire

// File: hdl/i2c_cmd_dispatch.sv
`default_nettype none

`include "i2c_wr_consts.svh"

module i2c_cmd_dispatch
	import i2c_wr_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cmd_strobe,
	input  i2c_cmd_t                 cmd,
	input  logic [`I2C_CHANNELS-1:0] chan_busy,
	output logic [`I2C_CHANNELS-1:0] start,
	output i2c_cmd_t                 eng_cmd,
	output logic                     cmd_drop
);

	logic                     occupied;
	logic                     accept;
	logic [`I2C_CHANNELS-1:0] sel_onehot;

	// a start still in flight counts as busy because the engine raises busy a cycle later
	assign occupied = chan_busy[cmd.channel] | start[cmd.channel];
	assign accept   = cmd_strobe & ~occupied;
	assign cmd_drop = cmd_strobe & occupied;

	always_comb begin
		sel_onehot              = '0;
		sel_onehot[cmd.channel] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			start <= '0;
		end else if (accept) begin
			start <= sel_onehot;
		end else begin
			start <= '0;
		end
	end

	// one register is shared because engines latch the command on their start pulse
	always_ff @(posedge clk) begin
		if (accept) begin
			eng_cmd <= cmd;
		end
	end

endmodule

`default_nettype wire

// File: hdl/i2c_write_engine.sv
`default_nettype none

`include "i2c_wr_consts.svh"

module i2c_write_engine
	import i2c_wr_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  i2c_cmd_t cmd,
	output logic     scl,
	output logic     sda_oe,
	input  logic     sda_in,
	output logic     busy,
	output logic     done,
	output i2c_res_t res
);

	localparam int QW = $clog2(`I2C_QUARTER);

	i2c_eng_state_e         state;
	logic [QW-1:0]          qcnt;
	logic [1:0]             ph;        // quarter index within one bit time
	logic [2:0]             bit_cnt;
	logic [1:0]             byte_idx;  // 0 address, 1 register, 2 data
	logic                   nack;
	i2c_phase_e             phase_q;
	i2c_cmd_t               cmd_q;
	logic [`I2C_BYTE_W-1:0] shreg;
	logic [`I2C_BYTE_W-1:0] next_byte;
	logic                   tick;
	logic                   end_bit;

	assign tick      = (qcnt == QW'(`I2C_QUARTER - 1));
	assign end_bit   = tick && (ph == 2'd3);
	assign busy      = (state != IDLE);
	assign next_byte = (byte_idx == 2'd0) ? cmd_q.reg_idx : cmd_q.data;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state    <= IDLE;
			qcnt     <= '0;
			ph       <= 2'd0;
			bit_cnt  <= 3'd0;
			byte_idx <= 2'd0;
			nack     <= 1'b0;
			phase_q  <= PH_OK;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (state != IDLE) begin
				qcnt <= tick ? '0 : qcnt + 1'b1;
				if (tick) begin
					ph <= ph + 2'd1;
				end
			end
			case (state)
				IDLE: begin
					if (start) begin
						state    <= START;
						qcnt     <= '0;
						ph       <= 2'd0;
						byte_idx <= 2'd0;
					end
				end
				START: begin
					if (end_bit) begin
						state   <= SHIFT;
						bit_cnt <= 3'd0;
					end
				end
				SHIFT: begin
					if (end_bit) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= ACK;
						end
					end
				end
				ACK: begin
					if (tick && ph == 2'd0) begin
						nack <= sda_in; // target holds SDA low to acknowledge
					end
					if (end_bit) begin
						if (nack) begin
							state <= STOP;
							case (byte_idx)
								2'd0:    phase_q <= PH_ADDR_NACK;
								2'd1:    phase_q <= PH_REG_NACK;
								default: phase_q <= PH_DATA_NACK;
							endcase
						end else if (byte_idx == 2'd2) begin
							state   <= STOP;
							phase_q <= PH_OK;
						end else begin
							state    <= SHIFT;
							byte_idx <= byte_idx + 2'd1;
						end
					end
				end
				STOP: begin
					if (end_bit) begin
						state <= IDLE;
						done  <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			cmd_q <= cmd;
			shreg <= {cmd.addr, 1'b0}; // write bit is zero
		end else if (state == SHIFT && end_bit) begin
			shreg <= shreg << 1;
		end else if (state == ACK && end_bit) begin
			shreg <= next_byte;
		end
	end

	// SCL is high in the middle two quarters of a bit, so SDA moves only while it is low
	always_comb begin
		case (state)
			START: begin
				scl    = (ph != 2'd3);
				sda_oe = (ph != 2'd0); // SDA falls while SCL is high
			end
			SHIFT: begin
				scl    = ph[0] ^ ph[1];
				sda_oe = ~shreg[`I2C_BYTE_W-1];
			end
			ACK: begin
				scl    = ph[0] ^ ph[1];
				sda_oe = 1'b0;
			end
			STOP: begin
				scl    = (ph != 2'd0);
				sda_oe = ~ph[1]; // SDA released while SCL is high
			end
			default: begin
				scl    = 1'b1;
				sda_oe = 1'b0;
			end
		endcase
	end

	assign res.channel = cmd_q.channel;
	assign res.tag     = cmd_q.tag;
	assign res.phase   = phase_q;
	assign res.addr    = cmd_q.addr;

endmodule

`default_nettype wire

// File: hdl/i2c_result_collect.sv
`default_nettype none

`include "i2c_wr_consts.svh"

module i2c_result_collect
	import i2c_wr_pkg::*;
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic     [`I2C_CHANNELS-1:0]        done,
	input  i2c_res_t [`I2C_CHANNELS-1:0]        eng_res,
	output logic     [`I2C_CHANNELS-1:0]        pending,
	output logic                                res_strobe,
	output i2c_res_t                            res
);

	logic     [`I2C_CHANNELS-1:0] pend_q;
	i2c_res_t [`I2C_CHANNELS-1:0] slot;
	logic     [`I2C_CH_W-1:0]     ptr;     // last channel served
	logic     [`I2C_CHANNELS-1:0] cand;
	logic     [`I2C_CH_W-1:0]     sel;
	logic                         found;
	i2c_res_t                     sel_res;

	// a fresh done counts as pending at once, so chan_busy never dips between engine and slot
	assign cand    = pend_q | done;
	assign pending = cand;

	always_comb begin
		logic [`I2C_CH_W-1:0] idx;
		found = 1'b0;
		sel   = '0;
		for (int i = 0; i < `I2C_CHANNELS; i++) begin
			idx = ptr + `I2C_CH_W'(i + 1);
			if (!found && cand[idx]) begin
				found = 1'b1;
				sel   = idx;
			end
		end
	end

	assign sel_res = pend_q[sel] ? slot[sel] : eng_res[sel];

	always_ff @(posedge clk) begin
		if (!rst) begin
			pend_q     <= '0;
			ptr        <= '0;
			res_strobe <= 1'b0;
		end else begin
			res_strobe <= found;
			if (found) begin
				ptr <= sel;
			end
			for (int k = 0; k < `I2C_CHANNELS; k++) begin
				if (found && sel == `I2C_CH_W'(k)) begin
					pend_q[k] <= 1'b0;
				end else if (done[k]) begin
					pend_q[k] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < `I2C_CHANNELS; k++) begin
			if (done[k]) begin
				slot[k] <= eng_res[k];
			end
		end
		if (found) begin
			res <= sel_res;
		end
	end

endmodule

`default_nettype wire

// File: hdl/i2c_multi_writer.sv
`default_nettype none

`include "i2c_wr_consts.svh"

module i2c_multi_writer
	import i2c_wr_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cmd_strobe,
	input  i2c_cmd_t                 cmd,
	output logic                     cmd_drop,
	output logic                     res_strobe,
	output i2c_res_t                 res,
	output logic [`I2C_CHANNELS-1:0] chan_busy,
	output logic [`I2C_CHANNELS-1:0] scl,
	output logic [`I2C_CHANNELS-1:0] sda_oe,
	input  logic [`I2C_CHANNELS-1:0] sda_in
);

	logic     [`I2C_CHANNELS-1:0] start;
	i2c_cmd_t                     eng_cmd;
	logic     [`I2C_CHANNELS-1:0] eng_busy;
	logic     [`I2C_CHANNELS-1:0] eng_done;
	i2c_res_t [`I2C_CHANNELS-1:0] eng_res;
	logic     [`I2C_CHANNELS-1:0] pending;

	// a channel stays busy until its result has left the collector
	assign chan_busy = eng_busy | pending;

	i2c_cmd_dispatch i2c_cmd_dispatch_inst (
		.clk        (clk),
		.rst        (rst),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.chan_busy  (chan_busy),
		.start      (start),
		.eng_cmd    (eng_cmd),
		.cmd_drop   (cmd_drop)
	);

	for (genvar k = 0; k < `I2C_CHANNELS; k++) begin : g_eng
		i2c_write_engine i2c_write_engine_inst (
			.clk    (clk),
			.rst    (rst),
			.start  (start[k]),
			.cmd    (eng_cmd),
			.scl    (scl[k]),
			.sda_oe (sda_oe[k]),
			.sda_in (sda_in[k]),
			.busy   (eng_busy[k]),
			.done   (eng_done[k]),
			.res    (eng_res[k])
		);
	end

	i2c_result_collect i2c_result_collect_inst (
		.clk        (clk),
		.rst        (rst),
		.done       (eng_done),
		.eng_res    (eng_res),
		.pending    (pending),
		.res_strobe (res_strobe),
		.res        (res)
	);

endmodule

`default_nettype wire

// File: sim/i2c_target_model.sv
`default_nettype none

`include "i2c_wr_consts.svh"

module i2c_target_model (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   scl,
	input  logic                   sda_oe,
	output logic                   sda_in,
	output logic [`I2C_BYTE_W-1:0] last_reg,
	output logic [`I2C_BYTE_W-1:0] last_data
);

	localparam logic [`I2C_ADDR_W-1:0] own_addr = 7'h1D;

	logic                   ack_oe;
	logic                   sda;
	logic                   scl_q;
	logic                   sda_q;
	logic                   active;
	logic                   matched;
	logic                   addr_hit;
	logic [3:0]             bit_cnt;   // 8 after a full byte, 9 during the acknowledge bit
	logic [1:0]             byte_cnt;
	logic [`I2C_BYTE_W-1:0] shift_q;
	logic [`I2C_BYTE_W-1:0] reg_buf;

	assign sda      = ~(sda_oe | ack_oe); // either side pulls the line low
	assign sda_in   = sda;
	assign addr_hit = (shift_q == {own_addr, 1'b0});

	// the lines are sampled on clk so zero-time glitches on scl are never seen as edges
	always_ff @(posedge clk) begin
		if (!rst) begin
			scl_q     <= 1'b1;
			sda_q     <= 1'b1;
			ack_oe    <= 1'b0;
			active    <= 1'b0;
			matched   <= 1'b0;
			bit_cnt   <= 4'd0;
			byte_cnt  <= 2'd0;
			last_reg  <= '0;
			last_data <= '0;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda) begin // start condition
				active   <= 1'b1;
				matched  <= 1'b0;
				ack_oe   <= 1'b0;
				bit_cnt  <= 4'd0;
				byte_cnt <= 2'd0;
			end else if (scl && scl_q && !sda_q && sda) begin // stop condition
				active <= 1'b0;
				ack_oe <= 1'b0;
			end else if (active && scl && !scl_q && bit_cnt < 4'd8) begin
				shift_q <= {shift_q[`I2C_BYTE_W-2:0], sda};
				bit_cnt <= bit_cnt + 4'd1;
			end else if (active && !scl && scl_q && bit_cnt == 4'd8) begin
				bit_cnt <= 4'd9;
				case (byte_cnt)
					2'd0: begin
						matched <= addr_hit;
						ack_oe  <= addr_hit;
					end
					2'd1: begin
						reg_buf <= shift_q;
						ack_oe  <= matched;
					end
					default: begin
						ack_oe <= matched;
						if (matched) begin
							last_reg  <= reg_buf;
							last_data <= shift_q;
						end
					end
				endcase
			end else if (active && !scl && scl_q && bit_cnt == 4'd9) begin
				ack_oe   <= 1'b0; // released once the acknowledge clock has fallen
				bit_cnt  <= 4'd0;
				byte_cnt <= byte_cnt + 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/i2c_multi_writer_chk.sv
`default_nettype none

module i2c_multi_writer_chk
	import i2c_wr_pkg::*;
(
	input logic           clk,
	input logic           rst,
	input i2c_eng_state_e state,
	input logic           scl,
	input logic           sda_oe,
	input logic           busy,
	input logic           done
);

	// START and STOP move SDA with SCL high on purpose, so only data and acknowledge bits count
	a_sda_scl_low: assert property (@(posedge clk) disable iff (!rst)
		(sda_oe != $past(sda_oe)) && (state inside {SHIFT, ACK})
			&& ($past(state) inside {SHIFT, ACK}) |-> !scl && !$past(scl))
		else $error("SDA changed while SCL was high");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	a_busy_reset: assert property (@(posedge clk) !rst |=> !busy)
		else $error("engine busy right after reset");

endmodule

bind i2c_write_engine i2c_multi_writer_chk i2c_multi_writer_chk_inst (
	.clk    (clk),
	.rst    (rst),
	.state  (state),
	.scl    (scl),
	.sda_oe (sda_oe),
	.busy   (busy),
	.done   (done)
);

`default_nettype wire

// File: sim/i2c_multi_writer_tb.sv
`default_nettype none

`include "i2c_wr_consts.svh"

module i2c_multi_writer_tb
	import i2c_wr_pkg::*;
();

	localparam int n_cmds         = 40;
	localparam int timeout_cycles = n_cmds * 500;
	localparam int byte_cycles    = 9 * 4 * `I2C_QUARTER; // one byte with its acknowledge bit
	localparam logic [`I2C_ADDR_W-1:0] ack_addr = 7'h1D;

	logic                                      clk;
	logic                                      rst;
	logic                                      cmd_strobe;
	i2c_cmd_t                                  cmd;
	logic                                      cmd_drop;
	logic                                      res_strobe;
	i2c_res_t                                  res;
	logic [`I2C_CHANNELS-1:0]                  chan_busy;
	logic [`I2C_CHANNELS-1:0]                  scl;
	logic [`I2C_CHANNELS-1:0]                  sda_oe;
	wire  [`I2C_CHANNELS-1:0]                  sda_in;
	wire  [`I2C_CHANNELS-1:0][`I2C_BYTE_W-1:0] tgt_reg;
	wire  [`I2C_CHANNELS-1:0][`I2C_BYTE_W-1:0] tgt_data;

	i2c_res_t               exp_q[$];  // results still owed and matched by tag
	int                     cycles;
	int                     drops_seen;
	int                     drops_exp;
	int                     seed;
	logic [`I2C_BYTE_W-1:0] next_tag;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	i2c_multi_writer i2c_multi_writer_inst (
		.clk        (clk),
		.rst        (rst),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.cmd_drop   (cmd_drop),
		.res_strobe (res_strobe),
		.res        (res),
		.chan_busy  (chan_busy),
		.scl        (scl),
		.sda_oe     (sda_oe),
		.sda_in     (sda_in)
	);

	for (genvar k = 0; k < `I2C_CHANNELS; k++) begin : g_tgt
		i2c_target_model i2c_target_model_inst (
			.clk       (clk),
			.rst       (rst),
			.scl       (scl[k]),
			.sda_oe    (sda_oe[k]),
			.sda_in    (sda_in[k]),
			.last_reg  (tgt_reg[k]),
			.last_data (tgt_data[k])
		);
	end

	function automatic i2c_phase_e expected_phase(input logic [`I2C_ADDR_W-1:0] addr);
		if (addr == ack_addr) begin
			return PH_OK;
		end
		return PH_ADDR_NACK; // nobody answers, so the address byte is the one refused
	endfunction

	function automatic i2c_res_t expected_res(input i2c_cmd_t c);
		i2c_res_t r;
		r.channel = c.channel;
		r.tag     = c.tag;
		r.phase   = expected_phase(c.addr);
		r.addr    = c.addr;
		return r;
	endfunction

	function automatic i2c_cmd_t rand_cmd(input logic [`I2C_CH_W-1:0] ch, input logic hit);
		i2c_cmd_t    c;
		logic [31:0] rnd;
		rnd       = $random(seed);
		c.channel = ch;
		c.addr    = hit ? ack_addr : rnd[`I2C_ADDR_W-1:0];
		if (!hit && c.addr == ack_addr) begin
			c.addr = ~ack_addr;
		end
		c.reg_idx = rnd[15:8];
		c.data    = rnd[23:16];
		c.tag     = next_tag; // a running tag keeps every tag unique
		next_tag  = next_tag + 1'b1;
		return c;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_res(input i2c_res_t got, input i2c_res_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: result ch %0d tag %h phase %0d addr %h, %s",
				$time, got.channel, got.tag, got.phase, got.addr,
				$sformatf("expected ch %0d tag %h phase %0d addr %h",
					exp.channel, exp.tag, exp.phase, exp.addr)));
		end
	endtask

	task automatic check_reg(input int ch, input logic [`I2C_BYTE_W-1:0] got_reg, got_data,
			exp_reg, exp_data);
		if (got_reg !== exp_reg || got_data !== exp_data) begin
			abort_run($sformatf("MISMATCH at %0t: target %0d holds reg %h data %h, expected %h %h",
				$time, ch, got_reg, got_data, exp_reg, exp_data));
		end
	endtask

	task automatic check_lines(input string what, input logic [`I2C_CHANNELS-1:0] got, exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_count(input string what, input int got, exp);
		if (got != exp) begin
			abort_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	// target keeps its old bytes unless the write went through
	task automatic check_target(input int ch, input i2c_cmd_t c,
			input logic [`I2C_BYTE_W-1:0] old_reg, old_data);
		if (expected_phase(c.addr) == PH_OK) begin
			check_reg(ch, tgt_reg[ch], tgt_data[ch], c.reg_idx, c.data);
		end else begin
			check_reg(ch, tgt_reg[ch], tgt_data[ch], old_reg, old_data);
		end
	endtask

	// called on a falling edge, so back to back calls give a strobe on consecutive cycles
	task automatic send_cmd(input i2c_cmd_t c, input logic drop);
		cmd_strobe = 1'b1;
		cmd        = c;
		if (drop) begin
			drops_exp++;
		end else begin
			exp_q.push_back(expected_res(c));
		end
		@(negedge clk);
		cmd_strobe = 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (chan_busy != '0) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk); // lets the last result strobe reach the compare process
	endtask

	task automatic single_write(input logic [`I2C_CH_W-1:0] ch, input logic hit);
		i2c_cmd_t               c;
		logic [`I2C_BYTE_W-1:0] old_reg;
		logic [`I2C_BYTE_W-1:0] old_data;
		c        = rand_cmd(ch, hit);
		old_reg  = tgt_reg[ch];
		old_data = tgt_data[ch];
		send_cmd(c, 1'b0);
		wait_idle();
		check_target(int'(ch), c, old_reg, old_data);
	endtask

	always @(posedge clk) begin
		int idx;
		idx = -1;
		if (rst && cmd_drop) begin
			drops_seen++;
		end
		if (rst && res_strobe) begin
			foreach (exp_q[i]) begin
				if (exp_q[i].tag == res.tag) begin
					idx = i;
				end
			end
			if (idx < 0) begin
				abort_run($sformatf("unexpected result with tag %h at time %0t", res.tag, $time));
			end else begin
				check_res(res, exp_q[idx]);
				exp_q.delete(idx);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > timeout_cycles) begin
			abort_run("timeout, the DUT never went idle");
		end
	end

	initial begin
		logic [31:0]            rnd;
		i2c_cmd_t               first;
		i2c_cmd_t               burst [`I2C_CHANNELS];
		logic [`I2C_BYTE_W-1:0] old_reg [`I2C_CHANNELS];
		logic [`I2C_BYTE_W-1:0] old_data [`I2C_CHANNELS];
		seed       = 32'hf85b;
		cycles     = 0;
		drops_seen = 0;
		drops_exp  = 0;
		next_tag   = '0;
		rst        = 1'b0;
		cmd_strobe = 1'b0;
		cmd        = '0;
		repeat (16) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_lines("chan_busy", chan_busy, '0);
		check_lines("scl", scl, '1);
		check_lines("sda_oe", sda_oe, '0);

		for (int k = 0; k < `I2C_CHANNELS; k++) begin
			single_write(`I2C_CH_W'(k), 1'b1);
		end
		for (int k = 0; k < `I2C_CHANNELS; k++) begin
			single_write(`I2C_CH_W'(k), 1'b0);
		end
		for (int i = 0; i < 20; i++) begin
			rnd = $random(seed);
			single_write(rnd[`I2C_CH_W-1:0], rnd[8]);
		end

		// second command lands while start is in flight, third while the engine runs
		first = rand_cmd(`I2C_CH_W'(2), 1'b1);
		send_cmd(first, 1'b0);
		send_cmd(rand_cmd(`I2C_CH_W'(2), 1'b1), 1'b1);
		repeat (20) @(negedge clk);
		send_cmd(rand_cmd(`I2C_CH_W'(2), 1'b0), 1'b1);
		wait_idle();
		check_reg(2, tgt_reg[2], tgt_data[2], first.reg_idx, first.data);
		check_count("cmd_drop pulses", drops_seen, drops_exp);

		for (int k = 0; k < `I2C_CHANNELS; k++) begin
			burst[k]    = rand_cmd(`I2C_CH_W'(k), k < `I2C_CHANNELS / 2);
			old_reg[k]  = tgt_reg[k];
			old_data[k] = tgt_data[k];
		end
		// an address NACK ends two bytes early, so each miss finishes in the same cycle as a hit
		for (int k = 0; k < `I2C_CHANNELS / 2; k++) begin
			send_cmd(burst[k], 1'b0);
		end
		repeat (2 * byte_cycles - `I2C_CHANNELS / 2) @(negedge clk);
		for (int k = `I2C_CHANNELS / 2; k < `I2C_CHANNELS; k++) begin
			send_cmd(burst[k], 1'b0);
		end
		wait_idle();
		for (int k = 0; k < `I2C_CHANNELS; k++) begin
			check_target(k, burst[k], old_reg[k], old_data[k]);
		end

		check_count("results still outstanding", exp_q.size(), 0);
		check_count("cmd_drop pulses", drops_seen, drops_exp);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/i2c_wr_pkg.sv
hdl/i2c_cmd_dispatch.sv
hdl/i2c_write_engine.sv
hdl/i2c_result_collect.sv
hdl/i2c_multi_writer.sv
sim/i2c_target_model.sv
sim/i2c_multi_writer_chk.sv
sim/i2c_multi_writer_tb.sv

// File: Makefile
TOP = i2c_multi_writer_tb

sim:
	verilator --binary --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
